//--- hdl/cpu_pkg.sv
package cpu_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_addr_t;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_srl,
        op_addi,
        op_lui,
        op_lw,
        op_sw,
        op_beq,
        op_bne,
        op_jal,
        op_out,
        op_halt
    } opcode_t;

    // Immediate is sign-extended in decode
    typedef struct packed {
        opcode_t     opcode;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [12:0] imm;
    } instr_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl
    } alu_op_t;

    typedef enum logic [1:0] {
        op1_rs1,
        op1_zero
    } op1_src_t;

    typedef enum logic [1:0] {
        op2_rs2,
        op2_imm,
        op2_upper_imm
    } op2_src_t;

    typedef enum logic [1:0] {
        pc_seq,
        pc_branch_zero,
        pc_branch_not_zero,
        pc_always
    } next_pc_src_t;

    typedef enum logic {
        wb_alu,
        wb_ram
    } wb_src_t;

    typedef struct packed {
        alu_op_t      alu_op;
        op1_src_t     op1_src;
        op2_src_t     op2_src;
        next_pc_src_t next_pc_src;
        wb_src_t      wb_src;
        logic         reg_write;
        logic         ram_write;
        logic         out_write;
        logic         halt;
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        instr_t          instr;
    } if_id_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1_data;
        logic [xlen-1:0] rs2_data;
        logic [xlen-1:0] imm;
        reg_addr_t       rd;
        ctrl_t           ctrl;
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1_data;
        logic [xlen-1:0] rs2_data;
        reg_addr_t       rd;
        logic [xlen-1:0] alu_result;
        logic            alu_zero;
        logic [xlen-1:0] branch_target;
        ctrl_t           ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic            reg_write;
        reg_addr_t       rd;
        logic [xlen-1:0] data;
    } wb_t;

    typedef struct packed {
        logic fetch;
        logic decode;
        logic execute;
        logic memory;
        logic writeback;
    } stage_en_t;

endpackage

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_t          op,
    input  logic [cpu_pkg::xlen-1:0]  a,
    input  logic [cpu_pkg::xlen-1:0]  b,
    output logic [cpu_pkg::xlen-1:0]  result,
    output logic                      zero
);

    always_comb begin
        case (op)
            cpu_pkg::alu_add: result = a + b;
            cpu_pkg::alu_sub: result = a - b;
            cpu_pkg::alu_and: result = a & b;
            cpu_pkg::alu_or:  result = a | b;
            cpu_pkg::alu_xor: result = a ^ b;
            // Shift amount from the low five bits only
            cpu_pkg::alu_sll: result = a << b[4:0];
            cpu_pkg::alu_srl: result = a >> b[4:0];
            default:          result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- hdl/state_controller.sv
`timescale 1ns/1ps

module state_controller (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               run,
    input  logic               halt_seen,
    output cpu_pkg::stage_en_t stage_en,
    output logic               pipe_clear,
    output logic               halted
);

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback,
        st_stopped
    } state_t;

    state_t state;
    state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            st_idle:      state_next = st_fetch;
            st_fetch:     state_next = st_decode;
            st_decode:    state_next = st_execute;
            st_execute:   state_next = st_memory;
            st_memory:    state_next = st_writeback;
            st_writeback: state_next = halt_seen ? st_stopped : st_fetch;
            st_stopped:   state_next = st_stopped;
            default:      state_next = st_idle;
        endcase
        // Run low always parks the core
        if (!run) begin
            state_next = st_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        stage_en.fetch     = (state == st_fetch);
        stage_en.decode    = (state == st_decode);
        stage_en.execute   = (state == st_execute);
        stage_en.memory    = (state == st_memory);
        stage_en.writeback = (state == st_writeback);
    end

    assign pipe_clear = (state == st_idle);
    assign halted     = (state == st_stopped);

endmodule

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter int prog_addr_width = 8
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  cpu_pkg::stage_en_t         stage_en,
    input  logic                       pipe_clear,
    input  logic                       prog_write,
    input  logic [prog_addr_width-1:0] prog_write_address,
    input  cpu_pkg::instr_t            prog_write_data,
    input  logic [cpu_pkg::xlen-1:0]   next_pc,
    output cpu_pkg::if_id_t            if_id
);

    cpu_pkg::instr_t          prog_mem [2**prog_addr_width];
    logic [cpu_pkg::xlen-1:0] pc;

    always_ff @(posedge clk) begin
        if (prog_write) begin
            prog_mem[prog_write_address] <= prog_write_data;
        end
    end

    // PC advances once per instruction at the end of writeback
    always_ff @(posedge clk) begin
        if (!reset_n || pipe_clear) begin
            pc    <= '0;
            if_id <= '0;
        end else begin
            if (stage_en.writeback) begin
                pc <= next_pc;
            end
            if (stage_en.fetch) begin
                if_id.pc    <= pc;
                if_id.instr <= prog_mem[pc[prog_addr_width-1:0]];
            end
        end
    end

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic               clk,
    input  logic               reset_n,
    input  cpu_pkg::stage_en_t stage_en,
    input  logic               pipe_clear,
    input  cpu_pkg::if_id_t    if_id,
    input  cpu_pkg::wb_t       wb,
    output cpu_pkg::id_ex_t    id_ex
);

    cpu_pkg::ctrl_t           ctrl;
    logic [cpu_pkg::xlen-1:0] imm;
    logic [cpu_pkg::xlen-1:0] regs [32];
    logic [cpu_pkg::xlen-1:0] rs1_data;
    logic [cpu_pkg::xlen-1:0] rs2_data;

    assign imm = {{(cpu_pkg::xlen-13){if_id.instr.imm[12]}}, if_id.instr.imm};

    always_comb begin
        ctrl             = '0;
        ctrl.alu_op      = cpu_pkg::alu_add;
        ctrl.op1_src     = cpu_pkg::op1_rs1;
        ctrl.op2_src     = cpu_pkg::op2_rs2;
        ctrl.next_pc_src = cpu_pkg::pc_seq;
        ctrl.wb_src      = cpu_pkg::wb_alu;
        case (if_id.instr.opcode)
            cpu_pkg::op_add: ctrl.reg_write = 1'b1;
            cpu_pkg::op_sub: begin
                ctrl.alu_op    = cpu_pkg::alu_sub;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::op_and: begin
                ctrl.alu_op    = cpu_pkg::alu_and;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::op_or: begin
                ctrl.alu_op    = cpu_pkg::alu_or;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::op_xor: begin
                ctrl.alu_op    = cpu_pkg::alu_xor;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::op_sll: begin
                ctrl.alu_op    = cpu_pkg::alu_sll;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::op_srl: begin
                ctrl.alu_op    = cpu_pkg::alu_srl;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::op_addi: begin
                ctrl.op2_src   = cpu_pkg::op2_imm;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::op_lui: begin
                ctrl.op1_src   = cpu_pkg::op1_zero;
                ctrl.op2_src   = cpu_pkg::op2_upper_imm;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::op_lw: begin
                ctrl.op2_src   = cpu_pkg::op2_imm;
                ctrl.wb_src    = cpu_pkg::wb_ram;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::op_sw: begin
                ctrl.op2_src   = cpu_pkg::op2_imm;
                ctrl.ram_write = 1'b1;
            end
            // Branches compare through a subtract
            cpu_pkg::op_beq: begin
                ctrl.alu_op      = cpu_pkg::alu_sub;
                ctrl.next_pc_src = cpu_pkg::pc_branch_zero;
            end
            cpu_pkg::op_bne: begin
                ctrl.alu_op      = cpu_pkg::alu_sub;
                ctrl.next_pc_src = cpu_pkg::pc_branch_not_zero;
            end
            cpu_pkg::op_jal: begin
                ctrl.next_pc_src = cpu_pkg::pc_always;
                ctrl.reg_write   = 1'b1;
            end
            cpu_pkg::op_out:  ctrl.out_write = 1'b1;
            cpu_pkg::op_halt: ctrl.halt      = 1'b1;
            default: ;
        endcase
    end

    // x0 never written and reads zero
    assign rs1_data = (if_id.instr.rs1 == '0) ? '0 : regs[if_id.instr.rs1];
    assign rs2_data = (if_id.instr.rs2 == '0) ? '0 : regs[if_id.instr.rs2];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (stage_en.writeback && wb.reg_write && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n || pipe_clear) begin
            id_ex <= '0;
        end else if (stage_en.decode) begin
            id_ex.pc       <= if_id.pc;
            id_ex.rs1_data <= rs1_data;
            id_ex.rs2_data <= rs2_data;
            id_ex.imm      <= imm;
            id_ex.rd       <= if_id.instr.rd;
            id_ex.ctrl     <= ctrl;
        end
    end

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic               clk,
    input  logic               reset_n,
    input  cpu_pkg::stage_en_t stage_en,
    input  logic               pipe_clear,
    input  cpu_pkg::id_ex_t    id_ex,
    output cpu_pkg::ex_mem_t   ex_mem
);

    logic [cpu_pkg::xlen-1:0] op1;
    logic [cpu_pkg::xlen-1:0] op2;
    logic [cpu_pkg::xlen-1:0] alu_result;
    logic                     alu_zero;
    logic [cpu_pkg::xlen-1:0] branch_target;

    assign op1 = (id_ex.ctrl.op1_src == cpu_pkg::op1_zero) ? '0 : id_ex.rs1_data;

    always_comb begin
        case (id_ex.ctrl.op2_src)
            cpu_pkg::op2_rs2:       op2 = id_ex.rs2_data;
            cpu_pkg::op2_imm:       op2 = id_ex.imm;
            cpu_pkg::op2_upper_imm: op2 = id_ex.imm << 12;
            default:                op2 = '0;
        endcase
    end

    alu alu_inst (
        .op     (id_ex.ctrl.alu_op),
        .a      (op1),
        .b      (op2),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // PC counts words so the offset adds directly
    assign branch_target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk) begin
        if (!reset_n || pipe_clear) begin
            ex_mem <= '0;
        end else if (stage_en.execute) begin
            ex_mem.pc            <= id_ex.pc;
            ex_mem.rs1_data      <= id_ex.rs1_data;
            ex_mem.rs2_data      <= id_ex.rs2_data;
            ex_mem.rd            <= id_ex.rd;
            ex_mem.alu_result    <= alu_result;
            ex_mem.alu_zero      <= alu_zero;
            ex_mem.branch_target <= branch_target;
            ex_mem.ctrl          <= id_ex.ctrl;
        end
    end

endmodule

//--- hdl/memory_stage.sv
`timescale 1ns/1ps

module memory_stage #(
    parameter int ram_addr_width = 6
) (
    input  logic                      clk,
    input  logic                      reset_n,
    input  cpu_pkg::stage_en_t        stage_en,
    input  logic                      pipe_clear,
    input  cpu_pkg::ex_mem_t          ex_mem,
    output logic [cpu_pkg::xlen-1:0]  next_pc,
    output cpu_pkg::wb_t              wb,
    output logic                      out_valid,
    output logic [7:0]                out_data,
    output logic                      halt_seen
);

    logic [cpu_pkg::xlen-1:0] ram [2**ram_addr_width];
    logic [ram_addr_width-1:0] ram_addr;
    logic [cpu_pkg::xlen-1:0] ram_rdata;
    logic [cpu_pkg::xlen-1:0] pc_plus_one;
    logic [cpu_pkg::xlen-1:0] next_pc_sel;
    logic [cpu_pkg::xlen-1:0] wb_data;

    // Address wraps on the low bits
    assign ram_addr    = ex_mem.alu_result[ram_addr_width-1:0];
    assign ram_rdata   = ram[ram_addr];
    assign pc_plus_one = ex_mem.pc + 1'b1;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < 2**ram_addr_width; i++) begin
                ram[i] <= '0;
            end
        end else if (stage_en.memory && ex_mem.ctrl.ram_write) begin
            ram[ram_addr] <= ex_mem.rs2_data;
        end
    end

    always_comb begin
        case (ex_mem.ctrl.next_pc_src)
            cpu_pkg::pc_branch_zero:
                next_pc_sel = ex_mem.alu_zero ? ex_mem.branch_target : pc_plus_one;
            cpu_pkg::pc_branch_not_zero:
                next_pc_sel = ex_mem.alu_zero ? pc_plus_one : ex_mem.branch_target;
            cpu_pkg::pc_always: next_pc_sel = ex_mem.branch_target;
            default:            next_pc_sel = pc_plus_one;
        endcase
    end

    always_comb begin
        if (ex_mem.ctrl.next_pc_src == cpu_pkg::pc_always) begin
            // jal links the return address
            wb_data = pc_plus_one;
        end else if (ex_mem.ctrl.wb_src == cpu_pkg::wb_ram) begin
            wb_data = ram_rdata;
        end else begin
            wb_data = ex_mem.alu_result;
        end
    end

    assign out_valid = stage_en.memory && ex_mem.ctrl.out_write;
    assign out_data  = ex_mem.rs1_data[7:0];

    always_ff @(posedge clk) begin
        if (!reset_n || pipe_clear) begin
            next_pc   <= '0;
            wb        <= '0;
            halt_seen <= 1'b0;
        end else if (stage_en.memory) begin
            next_pc      <= next_pc_sel;
            wb.reg_write <= ex_mem.ctrl.reg_write;
            wb.rd        <= ex_mem.rd;
            wb.data      <= wb_data;
            if (ex_mem.ctrl.halt) begin
                halt_seen <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/seq_cpu.sv
`timescale 1ns/1ps

module seq_cpu #(
    parameter int prog_addr_width = 8,
    parameter int ram_addr_width  = 6
) (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        run,
    input  logic                        prog_write,
    input  logic [prog_addr_width-1:0]  prog_write_address,
    input  cpu_pkg::instr_t             prog_write_data,
    output logic                        out_valid,
    output logic [7:0]                  out_data,
    output logic                        halted
);

    cpu_pkg::stage_en_t         stage_en;
    logic                       pipe_clear;
    logic                       halt_seen;
    cpu_pkg::if_id_t            if_id;
    cpu_pkg::id_ex_t            id_ex;
    cpu_pkg::ex_mem_t           ex_mem;
    cpu_pkg::wb_t               wb;
    logic [cpu_pkg::xlen-1:0]   next_pc;

    state_controller state_controller_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .run        (run),
        .halt_seen  (halt_seen),
        .stage_en   (stage_en),
        .pipe_clear (pipe_clear),
        .halted     (halted)
    );

    fetch_stage #(
        .prog_addr_width (prog_addr_width)
    ) fetch_stage_inst (
        .clk                (clk),
        .reset_n            (reset_n),
        .stage_en           (stage_en),
        .pipe_clear         (pipe_clear),
        .prog_write         (prog_write),
        .prog_write_address (prog_write_address),
        .prog_write_data    (prog_write_data),
        .next_pc            (next_pc),
        .if_id              (if_id)
    );

    decode_stage decode_stage_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .stage_en   (stage_en),
        .pipe_clear (pipe_clear),
        .if_id      (if_id),
        .wb         (wb),
        .id_ex      (id_ex)
    );

    execute_stage execute_stage_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .stage_en   (stage_en),
        .pipe_clear (pipe_clear),
        .id_ex      (id_ex),
        .ex_mem     (ex_mem)
    );

    memory_stage #(
        .ram_addr_width (ram_addr_width)
    ) memory_stage_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .stage_en   (stage_en),
        .pipe_clear (pipe_clear),
        .ex_mem     (ex_mem),
        .next_pc    (next_pc),
        .wb         (wb),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .halt_seen  (halt_seen)
    );

endmodule

//--- include/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

cpu_pkg::instr_t prog [max_prog_len];
int              prog_len;
logic [31:0]     model_regs [32];
logic [31:0]     model_ram [2**ram_addr_width];
logic [7:0]      exp_out [$];
int              exp_out_cycle [$];
int              exp_count;

function automatic int rand_below(input int limit);
    return int'($unsigned($random(seed)) % limit);
endfunction

function automatic cpu_pkg::opcode_t pick_opcode(input int mode);
    int sel;
    sel = rand_below(15);
    case (mode)
        0: return (sel > 8) ? cpu_pkg::op_out : cpu_pkg::opcode_t'(sel[3:0]);
        1: begin
            case (sel % 4)
                0: return cpu_pkg::op_sw;
                1: return cpu_pkg::op_lw;
                2: return cpu_pkg::op_addi;
                default: return cpu_pkg::op_out;
            endcase
        end
        2: begin
            case (sel % 5)
                0: return cpu_pkg::op_beq;
                1: return cpu_pkg::op_bne;
                2: return cpu_pkg::op_jal;
                3: return cpu_pkg::op_addi;
                default: return cpu_pkg::op_out;
            endcase
        end
        default: return cpu_pkg::opcode_t'(sel[3:0]);
    endcase
endfunction

// Opcode mix by mode is ALU, memory, control flow, then all
task automatic make_program(input int mode);
    cpu_pkg::instr_t ins;
    int              reg_span;
    prog_len = 4 + rand_below(max_prog_len - 3);
    reg_span = (mode == 2) ? 4 : 8;
    for (int i = 0; i < prog_len - 1; i++) begin
        ins        = cpu_pkg::instr_t'($random(seed));
        ins.opcode = pick_opcode(mode);
        ins.rd     = 5'(rand_below(reg_span));
        ins.rs1    = 5'(rand_below(reg_span));
        ins.rs2    = 5'(rand_below(reg_span));
        // Few distinct RAM words and offsets that wrap the address
        if (mode == 1 && (ins.opcode == cpu_pkg::op_sw || ins.opcode == cpu_pkg::op_lw)) begin
            ins.rs1 = 5'(rand_below(2));
            ins.imm = 13'(rand_below(8) * 64 + rand_below(4));
        end
        // Forward targets that never pass the HALT
        if (ins.opcode inside {cpu_pkg::op_beq, cpu_pkg::op_bne, cpu_pkg::op_jal}) begin
            ins.imm = 13'(1 + rand_below(prog_len - 1 - i));
        end
        prog[i] = ins;
    end
    ins            = '0;
    ins.opcode     = cpu_pkg::op_halt;
    prog[prog_len - 1] = ins;
endtask

task automatic run_model();
    cpu_pkg::instr_t ins;
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     imm;
    logic [31:0]     res;
    logic [31:0]     addr;
    logic            wr;
    logic            done;
    int              pc;
    int              next;
    exp_out.delete();
    exp_out_cycle.delete();
    exp_count = 0;
    pc        = 0;
    done      = 1'b0;
    while (!done) begin
        ins  = prog[pc];
        a    = model_regs[ins.rs1];
        b    = model_regs[ins.rs2];
        imm  = {{19{ins.imm[12]}}, ins.imm};
        addr = (a + imm) % (2**ram_addr_width);
        res  = '0;
        wr   = 1'b1;
        next = pc + 1;
        exp_count++;
        case (ins.opcode)
            cpu_pkg::op_add:  res = a + b;
            cpu_pkg::op_sub:  res = a - b;
            cpu_pkg::op_and:  res = a & b;
            cpu_pkg::op_or:   res = a | b;
            cpu_pkg::op_xor:  res = a ^ b;
            cpu_pkg::op_sll:  res = a << b[4:0];
            cpu_pkg::op_srl:  res = a >> b[4:0];
            cpu_pkg::op_addi: res = a + imm;
            cpu_pkg::op_lui:  res = imm << 12;
            cpu_pkg::op_lw:   res = model_ram[addr];
            cpu_pkg::op_sw: begin
                model_ram[addr] = b;
                wr = 1'b0;
            end
            cpu_pkg::op_beq: begin
                wr = 1'b0;
                if (a == b) next = pc + int'(imm);
            end
            cpu_pkg::op_bne: begin
                wr = 1'b0;
                if (a != b) next = pc + int'(imm);
            end
            cpu_pkg::op_jal: begin
                res  = 32'(pc + 1);
                next = pc + int'(imm);
            end
            cpu_pkg::op_out: begin
                wr = 1'b0;
                exp_out.push_back(a[7:0]);
                // Memory cycle of this instruction, counted from the run edge
                exp_out_cycle.push_back(5 * (exp_count - 1) + 4);
            end
            default: begin
                wr   = 1'b0;
                done = 1'b1;
            end
        endcase
        if (wr && ins.rd != 5'd0) begin
            model_regs[ins.rd] = res;
        end
        pc = next;
    end
endtask

`endif

//--- bench/seq_cpu_tb.sv
`timescale 1ns/1ps

module seq_cpu_tb;

    localparam int prog_addr_width = 8;
    localparam int ram_addr_width  = 6;
    localparam int max_prog_len    = 24;
    localparam int num_tests       = 12;
    // Twice the program load, worst-case run and margin of every test
    localparam int cycle_limit = num_tests * (max_prog_len + 5 * max_prog_len + 10) * 2;

    logic                       clk;
    logic                       reset_n;
    logic                       run;
    logic                       prog_write;
    logic [prog_addr_width-1:0] prog_write_address;
    cpu_pkg::instr_t            prog_write_data;
    logic                       out_valid;
    logic [7:0]                 out_data;
    logic                       halted;

    integer seed;
    int     error_count;
    int     failed_tests;
    int     cycle_count;

    `include "cpu_model.svh"

    seq_cpu #(
        .prog_addr_width (prog_addr_width),
        .ram_addr_width  (ram_addr_width)
    ) seq_cpu_inst (
        .clk                (clk),
        .reset_n            (reset_n),
        .run                (run),
        .prog_write         (prog_write),
        .prog_write_address (prog_write_address),
        .prog_write_data    (prog_write_data),
        .out_valid          (out_valid),
        .out_data           (out_data),
        .halted             (halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR: simulation timed out after %0d cycles", cycle_count);
        $display(">>> FAIL");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL at %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, actual,
                     expected);
            error_count++;
        end
    endtask

    function automatic string mode_name(input int mode);
        case (mode)
            0: return "alu";
            1: return "memory";
            2: return "branch";
            default: return "mixed";
        endcase
    endfunction

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(negedge clk);
            prog_write         = 1'b1;
            prog_write_address = prog_addr_width'(i);
            prog_write_data    = prog[i];
        end
        @(negedge clk);
        prog_write = 1'b0;
    endtask

    task automatic run_test(input int test_num, input int mode);
        int errors_before;
        int cycles;
        int out_index;
        errors_before = error_count;
        make_program(mode);
        run_model();
        load_program();
        @(negedge clk);
        run       = 1'b1;
        cycles    = 0;
        out_index = 0;
        // First falling edge after the edge that samples run counts as 1
        do begin
            @(negedge clk);
            cycles++;
            if (out_valid) begin
                if (out_index < exp_out.size()) begin
                    check_value("out_data", 32'(out_data), 32'(exp_out[out_index]));
                    check_value("out_valid cycle", cycles, exp_out_cycle[out_index]);
                end
                out_index++;
            end
        end while (!halted);
        check_value("out_valid count", out_index, exp_out.size());
        check_value("halted latency", cycles, 5 * exp_count + 1);
        repeat (3) begin
            @(negedge clk);
            check_value("out_valid", 32'(out_valid), 32'd0);
            check_value("halted", 32'(halted), 32'd1);
        end
        run = 1'b0;
        @(negedge clk);
        @(negedge clk);
        check_value("halted", 32'(halted), 32'd0);
        if (error_count != errors_before) begin
            failed_tests++;
        end
        $display("Test %0d (%s): %0d instructions, %0d bytes out, %s", test_num,
                 mode_name(mode), exp_count, out_index,
                 (error_count == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        seed               = 86;
        error_count        = 0;
        failed_tests       = 0;
        reset_n            = 1'b0;
        run                = 1'b0;
        prog_write         = 1'b0;
        prog_write_address = '0;
        prog_write_data    = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < 2**ram_addr_width; i++) begin
            model_ram[i] = '0;
        end
        repeat (2) @(negedge clk);
        reset_n = 1'b1;

        // Idle core stays quiet while run is low
        repeat (10) begin
            @(negedge clk);
            check_value("out_valid", 32'(out_valid), 32'd0);
            check_value("halted", 32'(halted), 32'd0);
        end
        if (error_count != 0) begin
            failed_tests++;
        end
        $display("Test 0 (reset idle): %s", (error_count == 0) ? "ok" : "failed");

        for (int t = 0; t < num_tests; t++) begin
            run_test(t + 1, t / 3);
        end

        $display("Tests: %0d run, %0d failed, %0d check errors", num_tests + 1, failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- seq_cpu.f
+incdir+include
hdl/cpu_pkg.sv
hdl/alu.sv
hdl/state_controller.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/seq_cpu.sv
bench/seq_cpu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the seq_cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f seq_cpu.f --top-module seq_cpu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vseq_cpu_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx ">>> PASS"; then
    exit 0
fi
exit 1
